// ==== list.f ====
+incdir+rtl
rtl/notepad_pkg.sv
rtl/key_fifo.sv
rtl/cursor_pos.sv
rtl/glyph_rom.sv
rtl/pixel_emitter.sv
rtl/text_ctrl.sv
rtl/notepad_top.sv
dv/notepad_chk.sv
dv/notepad_scoreboard.sv
dv/notepad_tb.sv

// ==== Bender.yml ====
package:
  name: notepad

export_include_dirs:
  - rtl

sources:
  - rtl/notepad_pkg.sv
  - rtl/key_fifo.sv
  - rtl/cursor_pos.sv
  - rtl/glyph_rom.sv
  - rtl/pixel_emitter.sv
  - rtl/text_ctrl.sv
  - rtl/notepad_top.sv
  - target: test
    files:
      - dv/notepad_chk.sv
      - dv/notepad_scoreboard.sv
      - dv/notepad_tb.sv

// ==== rtl/glyphs.hex ====
// One glyph per line for codes 0x20 to 0x7F, 32 hex digits, 16 rows of 8 pixels
// Leftmost digit holds bit 127, the top-left pixel
007E00FF00FF00FF00FF00FF00FF7E00
007E01FE01FE01FE01FE01FE01FE7E00
007E02FD02FD02FD02FD02FD02FD7E00
007E03FC03FC03FC03FC03FC03FC7E00
007E04FB04FB04FB04FB04FB04FB7E00
007E05FA05FA05FA05FA05FA05FA7E00
007E06F906F906F906F906F906F97E00
007E07F807F807F807F807F807F87E00
007E08F708F708F708F708F708F77E00
007E09F609F609F609F609F609F67E00
007E0AF50AF50AF50AF50AF50AF57E00
007E0BF40BF40BF40BF40BF40BF47E00
007E0CF30CF30CF30CF30CF30CF37E00
007E0DF20DF20DF20DF20DF20DF27E00
007E0EF10EF10EF10EF10EF10EF17E00
007E0FF00FF00FF00FF00FF00FF07E00
007E10EF10EF10EF10EF10EF10EF7E00
007E11EE11EE11EE11EE11EE11EE7E00
007E12ED12ED12ED12ED12ED12ED7E00
007E13EC13EC13EC13EC13EC13EC7E00
007E14EB14EB14EB14EB14EB14EB7E00
007E15EA15EA15EA15EA15EA15EA7E00
007E16E916E916E916E916E916E97E00
007E17E817E817E817E817E817E87E00
007E18E718E718E718E718E718E77E00
007E19E619E619E619E619E619E67E00
007E1AE51AE51AE51AE51AE51AE57E00
007E1BE41BE41BE41BE41BE41BE47E00
007E1CE31CE31CE31CE31CE31CE37E00
007E1DE21DE21DE21DE21DE21DE27E00
007E1EE11EE11EE11EE11EE11EE17E00
007E1FE01FE01FE01FE01FE01FE07E00
007E20DF20DF20DF20DF20DF20DF7E00
007E21DE21DE21DE21DE21DE21DE7E00
007E22DD22DD22DD22DD22DD22DD7E00
007E23DC23DC23DC23DC23DC23DC7E00
007E24DB24DB24DB24DB24DB24DB7E00
007E25DA25DA25DA25DA25DA25DA7E00
007E26D926D926D926D926D926D97E00
007E27D827D827D827D827D827D87E00
007E28D728D728D728D728D728D77E00
007E29D629D629D629D629D629D67E00
007E2AD52AD52AD52AD52AD52AD57E00
007E2BD42BD42BD42BD42BD42BD47E00
007E2CD32CD32CD32CD32CD32CD37E00
007E2DD22DD22DD22DD22DD22DD27E00
007E2ED12ED12ED12ED12ED12ED17E00
007E2FD02FD02FD02FD02FD02FD07E00
007E30CF30CF30CF30CF30CF30CF7E00
007E31CE31CE31CE31CE31CE31CE7E00
007E32CD32CD32CD32CD32CD32CD7E00
007E33CC33CC33CC33CC33CC33CC7E00
007E34CB34CB34CB34CB34CB34CB7E00
007E35CA35CA35CA35CA35CA35CA7E00
007E36C936C936C936C936C936C97E00
007E37C837C837C837C837C837C87E00
007E38C738C738C738C738C738C77E00
007E39C639C639C639C639C639C67E00
007E3AC53AC53AC53AC53AC53AC57E00
007E3BC43BC43BC43BC43BC43BC47E00
007E3CC33CC33CC33CC33CC33CC37E00
007E3DC23DC23DC23DC23DC23DC27E00
007E3EC13EC13EC13EC13EC13EC17E00
007E3FC03FC03FC03FC03FC03FC07E00
007E40BF40BF40BF40BF40BF40BF7E00
007E41BE41BE41BE41BE41BE41BE7E00
007E42BD42BD42BD42BD42BD42BD7E00
007E43BC43BC43BC43BC43BC43BC7E00
007E44BB44BB44BB44BB44BB44BB7E00
007E45BA45BA45BA45BA45BA45BA7E00
007E46B946B946B946B946B946B97E00
007E47B847B847B847B847B847B87E00
007E48B748B748B748B748B748B77E00
007E49B649B649B649B649B649B67E00
007E4AB54AB54AB54AB54AB54AB57E00
007E4BB44BB44BB44BB44BB44BB47E00
007E4CB34CB34CB34CB34CB34CB37E00
007E4DB24DB24DB24DB24DB24DB27E00
007E4EB14EB14EB14EB14EB14EB17E00
007E4FB04FB04FB04FB04FB04FB07E00
007E50AF50AF50AF50AF50AF50AF7E00
007E51AE51AE51AE51AE51AE51AE7E00
007E52AD52AD52AD52AD52AD52AD7E00
007E53AC53AC53AC53AC53AC53AC7E00
007E54AB54AB54AB54AB54AB54AB7E00
007E55AA55AA55AA55AA55AA55AA7E00
007E56A956A956A956A956A956A97E00
007E57A857A857A857A857A857A87E00
007E58A758A758A758A758A758A77E00
007E59A659A659A659A659A659A67E00
007E5AA55AA55AA55AA55AA55AA57E00
007E5BA45BA45BA45BA45BA45BA47E00
007E5CA35CA35CA35CA35CA35CA37E00
007E5DA25DA25DA25DA25DA25DA27E00
007E5EA15EA15EA15EA15EA15EA17E00
007E5FA05FA05FA05FA05FA05FA07E00

// ==== dv/notepad_tb.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module notepad_tb
    import notepad_pkg::*;
();
    localparam int NUM_KEYS = 60;
    localparam int TIMEOUT_CYCLES = NUM_KEYS * `NP_GLYPH_BITS * 5;
    localparam logic [31:0] SEED = 32'ha8c4;

    logic clk = 1'b0;
    logic arst_n = 1'b1;
    logic key_valid = 1'b0;
    key_t key = '0;
    logic pix_credit = 1'b0;
    logic key_credit;
    logic pix_valid;
    pixel_wr_t pix;
    logic [5:0] col;
    logic [3:0] row;
    logic end_check = 1'b0;

    logic [31:0] lfsr_q = SEED;
    int cycle = 0;
    int keys_sent = 0;
    int key_credits = `NP_KEY_DEPTH;   // Sender side
    int due_q[$];                      // Cycles at which pixel credits go back
    int sb_errors;
    int sb_pending;
    int chk_errors;

    notepad_top u_dut (
        .clk(clk),
        .arst_n(arst_n),
        .key_valid(key_valid),
        .key(key),
        .key_credit(key_credit),
        .pix_valid(pix_valid),
        .pix(pix),
        .pix_credit(pix_credit),
        .col(col),
        .row(row)
    );

    notepad_scoreboard #(
        .NUM_KEYS(NUM_KEYS)
    ) u_sb (
        .clk(clk),
        .arst_n(arst_n),
        .key_valid(key_valid),
        .key(key),
        .key_credit(key_credit),
        .pix_valid(pix_valid),
        .pix(pix),
        .pix_credit(pix_credit),
        .col(col),
        .row(row),
        .end_check(end_check),
        .errors(sb_errors),
        .pending(sb_pending)
    );

    bind notepad_top notepad_chk u_chk (
        .clk(clk),
        .arst_n(arst_n),
        .key_valid(key_valid),
        .key_credit(key_credit),
        .pix_valid(pix_valid),
        .pix_credit(pix_credit),
        .col(col),
        .row(row)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    always @(negedge clk)
    begin
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Run did not drain within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
    endtask

    function automatic logic is_control(input logic [6:0] code);
        return code == `NP_KEY_LEFT || code == `NP_KEY_RIGHT || code == `NP_KEY_UP
            || code == `NP_KEY_DOWN || code == `NP_KEY_HOME || code == `NP_KEY_END
            || code == `NP_KEY_ENTER;
    endfunction

    // 60% printable, 30% control, 10% other
    task automatic pick_key(output key_t k);
        int r;
        int v;
        rand_bits(10, r);
        r = r % 10;
        if (r < 6)
        begin
            rand_bits(7, v);
            k.code = 7'(`NP_FIRST_PRINT + v % 95);
        end
        else if (r < 9)
        begin
            rand_bits(8, v);
            case (v % 7)
                0: k.code = `NP_KEY_LEFT;
                1: k.code = `NP_KEY_RIGHT;
                2: k.code = `NP_KEY_UP;
                3: k.code = `NP_KEY_DOWN;
                4: k.code = `NP_KEY_HOME;
                5: k.code = `NP_KEY_END;
                default: k.code = `NP_KEY_ENTER;
            endcase
        end
        else
        begin
            rand_bits(5, v);
            k.code = 7'(v);
            if (is_control(k.code))
            begin
                k.code = 7'h7F;
            end
        end
    endtask

    task automatic drive_inputs();
        int v;
        key_t k;
        v = 0;
        if (keys_sent < NUM_KEYS && key_credits > 0)
        begin
            rand_bits(2, v);   // Idle gaps between keys
        end
        if (v != 0)
        begin
            pick_key(k);
            key <= k;
            key_valid <= 1'b1;
            key_credits--;
            keys_sent++;
        end
        else
        begin
            key_valid <= 1'b0;
        end
        if (due_q.size() > 0 && due_q[0] <= cycle)
        begin
            pix_credit <= 1'b1;
            void'(due_q.pop_front());
        end
        else
        begin
            pix_credit <= 1'b0;
        end
    endtask

    task automatic sample_outputs();
        int d;
        if (key_credit)
        begin
            key_credits++;
        end
        if (pix_valid)
        begin
            rand_bits(2, d);
            due_q.push_back(cycle + d);
        end
    endtask

    function automatic logic drained();
        return keys_sent == NUM_KEYS && key_credits == `NP_KEY_DEPTH
            && sb_pending == 0 && due_q.size() == 0;
    endfunction

    initial
    begin
        #1 arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        forever
        begin
            @(posedge clk);
            if (drained())
            begin
                break;
            end
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        key_valid <= 1'b0;
        pix_credit <= 1'b0;
        repeat (4) @(posedge clk);   // Last cursor move settles
        end_check <= 1'b1;
        @(posedge clk);
        end_check <= 1'b0;
        @(posedge clk);
        chk_errors = u_dut.u_chk.errors;
        $display("Errors: scoreboard %0d, assertions %0d", sb_errors, chk_errors);
        if (sb_errors == 0 && chk_errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/notepad_scoreboard.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module notepad_scoreboard
    import notepad_pkg::*;
#(
    parameter int NUM_KEYS = 60
)
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       key_valid,
    input  key_t       key,
    input  logic       key_credit,
    input  logic       pix_valid,
    input  pixel_wr_t  pix,
    input  logic       pix_credit,
    input  logic [5:0] col,
    input  logic [3:0] row,
    input  logic       end_check,
    output int         errors,
    output int         pending
);
    localparam int MAX_COL = `NP_COLS - 1;
    localparam int MAX_ROW = `NP_ROWS - 1;

    logic [`NP_GLYPH_BITS-1:0] glyphs [96];
    logic [`NP_GLYPH_BITS-1:0] cur_glyph;
    key_t keys_q[$];   // Keys accepted but not yet consumed by the model
    key_t cur_key;
    logic drawing;
    int mcol;
    int mrow;
    int bit_idx;
    int keys_in;
    int credits_out;
    int writes;
    int returned;

    initial
    begin
        $readmemh("rtl/glyphs.hex", glyphs);
        errors = 0;
        pending = 0;
        drawing = 1'b0;
        mcol = 0;
        mrow = 0;
        bit_idx = 0;
        keys_in = 0;
        credits_out = 0;
        writes = 0;
        returned = 0;
    end

    function automatic logic is_print(input logic [6:0] code);
        return code >= `NP_FIRST_PRINT && code <= `NP_LAST_PRINT;
    endfunction

    task automatic row_down();
        if (mrow < MAX_ROW)
        begin
            mrow++;
        end
    endtask

    task automatic advance();
        if (mcol < MAX_COL)
        begin
            mcol++;
        end
        else
        begin
            mcol = 0;
            row_down();
        end
    endtask

    task automatic retreat();
        if (mcol > 0)
        begin
            mcol--;
        end
        else
        begin
            mcol = MAX_COL;
            mrow = (mrow > 0) ? mrow - 1 : 0;
        end
    endtask

    task automatic apply_key(input logic [6:0] code);
        case (code)
            `NP_KEY_LEFT:  retreat();
            `NP_KEY_RIGHT: advance();
            `NP_KEY_UP:    mrow = (mrow > 0) ? mrow - 1 : 0;
            `NP_KEY_DOWN:  row_down();
            `NP_KEY_HOME:  mcol = 0;
            `NP_KEY_END:   mcol = MAX_COL;
            `NP_KEY_ENTER:
            begin
                mcol = 0;
                row_down();
            end
            default: ;   // Unknown codes leave the cursor alone
        endcase
    endtask

    // Consume queued keys up to the next printable one
    task automatic start_glyph();
        key_t k;
        while (keys_q.size() > 0 && !drawing)
        begin
            k = keys_q.pop_front();
            if (is_print(k.code))
            begin
                cur_key = k;
                cur_glyph = glyphs[k.code - `NP_FIRST_PRINT];
                bit_idx = 0;
                drawing = 1'b1;
            end
            else
            begin
                apply_key(k.code);
            end
        end
        if (!drawing)
        begin
            errors++;
            $display("Pixel write arrived with no printable key waiting");
        end
    endtask

    task automatic check_pixel();
        pixel_wr_t exp;
        if (!drawing)
        begin
            start_glyph();
        end
        if (drawing)
        begin
            exp.x = 9'(mcol * `NP_GLYPH_W + bit_idx % `NP_GLYPH_W);
            exp.y = 8'(mrow * `NP_GLYPH_H + bit_idx / `NP_GLYPH_W);
            exp.colour = cur_glyph[`NP_GLYPH_BITS - 1 - bit_idx] ? `NP_FG_COLOUR
                                                                  : `NP_BG_COLOUR;
            if (pix !== exp)
            begin
                errors++;
                $display("[ERROR] glyph_pixel key %h bit %0d: expected %0d,%0d,%0d actual %0d,%0d,%0d",
                         cur_key.code, bit_idx, exp.x, exp.y, exp.colour,
                         pix.x, pix.y, pix.colour);
            end
            bit_idx++;
            if (bit_idx == `NP_GLYPH_BITS)
            begin
                drawing = 1'b0;
                pending--;
                advance();
            end
        end
    endtask

    task automatic final_check();
        key_t k;
        if (drawing)
        begin
            errors++;
            $display("Glyph for key %h stopped after %0d pixel writes", cur_key.code, bit_idx);
        end
        while (keys_q.size() > 0)
        begin
            k = keys_q.pop_front();
            if (is_print(k.code))
            begin
                errors++;
                $display("Printable key %h was never drawn", k.code);
            end
            else
            begin
                apply_key(k.code);
            end
        end
        if (int'(col) != mcol)
        begin
            errors++;
            $display("[ERROR] final_cursor_col: expected %0d actual %0d", mcol, col);
        end
        if (int'(row) != mrow)
        begin
            errors++;
            $display("[ERROR] final_cursor_row: expected %0d actual %0d", mrow, row);
        end
        if (credits_out != NUM_KEYS)
        begin
            errors++;
            $display("[ERROR] key_credit_total: expected %0d actual %0d", NUM_KEYS, credits_out);
        end
    endtask

    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (key_valid)
            begin
                keys_q.push_back(key);
                keys_in++;
                if (is_print(key.code))
                begin
                    pending++;
                end
            end
            if (key_credit)
            begin
                credits_out++;
                if (credits_out > keys_in)
                begin
                    errors++;
                    $display("More key credits returned than keys sent");
                end
            end
            if (pix_valid)
            begin
                writes++;
                if (writes > returned + `NP_PIX_CREDITS)
                begin
                    errors++;
                    $display("Pixel writes exceed the credits returned plus the initial credits");
                end
                check_pixel();
            end
            if (pix_credit)
            begin
                returned++;   // Usable by the DUT from the next edge
            end
            if (int'(col) > MAX_COL || int'(row) > MAX_ROW)
            begin
                errors++;
                $display("Cursor outside the screen at column %0d row %0d", col, row);
            end
            if (end_check)
            begin
                final_check();
            end
        end
    end

endmodule

// ==== dv/notepad_chk.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module notepad_chk
(
    input logic       clk,
    input logic       arst_n,
    input logic       key_valid,
    input logic       key_credit,
    input logic       pix_valid,
    input logic       pix_credit,
    input logic [5:0] col,
    input logic [3:0] row
);
    int errors = 0;
    int key_occ;    // Entries held by the key FIFO
    int pix_held;   // Pixel credits held by the DUT

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_occ  <= 0;
            pix_held <= `NP_PIX_CREDITS;
        end
        else
        begin
            key_occ  <= key_occ + int'(key_valid) - int'(key_credit);
            pix_held <= pix_held + int'(pix_credit) - int'(pix_valid);
        end
    end

    a_fifo_not_full: assert property (@(posedge clk) disable iff (!arst_n)
        key_valid |-> key_occ < `NP_KEY_DEPTH)
    else
    begin
        errors++;
        $error("Key pushed while the key FIFO was full");
    end

    a_credit_has_key: assert property (@(posedge clk) disable iff (!arst_n)
        key_credit |-> key_occ > 0)
    else
    begin
        errors++;
        $error("Key credit returned with the FIFO empty");
    end

    a_pix_credit: assert property (@(posedge clk) disable iff (!arst_n)
        pix_valid |-> pix_held > 0)
    else
    begin
        errors++;
        $error("Pixel write issued without a credit");
    end

    a_col_range: assert property (@(posedge clk) disable iff (!arst_n)
        col <= 6'(`NP_COLS - 1))
    else
    begin
        errors++;
        $error("Cursor column beyond last column");
    end

    a_row_range: assert property (@(posedge clk) disable iff (!arst_n)
        row <= 4'(`NP_ROWS - 1))
    else
    begin
        errors++;
        $error("Cursor row beyond last row");
    end

    // Outputs stay quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !pix_valid && !key_credit && col == '0 && row == '0)
    else
    begin
        errors++;
        $error("DUT outputs active during reset");
    end

endmodule

// ==== rtl/notepad_top.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module notepad_top
    import notepad_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      key_valid,
    input  key_t      key,
    output logic      key_credit,
    output logic      pix_valid,
    output pixel_wr_t pix,
    input  logic      pix_credit,
    output logic [5:0] col,
    output logic [3:0] row
);
    logic key_pop;
    logic key_avail;
    key_t key_head;
    key_t glyph_req;
    logic [`NP_GLYPH_BITS-1:0] glyph;
    logic draw_start;
    logic draw_done;
    cursor_cmd_t cursor_cmd;

    key_fifo #(
        .DEPTH(`NP_KEY_DEPTH)
    ) u_key_fifo (
        .clk(clk),
        .arst_n(arst_n),
        .push(key_valid),
        .push_key(key),
        .pop(key_pop),
        .avail(key_avail),
        .head(key_head),
        .credit(key_credit)
    );

    text_ctrl u_text_ctrl (
        .clk(clk),
        .arst_n(arst_n),
        .key_avail(key_avail),
        .key_head(key_head),
        .key_pop(key_pop),
        .glyph_req(glyph_req),
        .draw_start(draw_start),
        .draw_done(draw_done),
        .cursor_cmd(cursor_cmd)
    );

    glyph_rom u_glyph_rom (
        .clk(clk),
        .code(glyph_req),
        .glyph(glyph)
    );

    pixel_emitter u_pixel_emitter (
        .clk(clk),
        .arst_n(arst_n),
        .start(draw_start),
        .glyph(glyph),
        .col(col),
        .row(row),
        .pix_valid(pix_valid),
        .pix(pix),
        .pix_credit(pix_credit),
        .done(draw_done)
    );

    cursor_pos u_cursor_pos (
        .clk(clk),
        .arst_n(arst_n),
        .cmd(cursor_cmd),
        .col(col),
        .row(row)
    );

endmodule

// ==== rtl/text_ctrl.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module text_ctrl
    import notepad_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        key_avail,
    input  key_t        key_head,
    output logic        key_pop,
    output key_t        glyph_req,
    output logic        draw_start,
    input  logic        draw_done,
    output cursor_cmd_t cursor_cmd
);
    typedef enum logic [2:0]
    {
        st_idle,
        st_decode,
        st_glyph_wait,
        st_draw,
        st_move
    } state_t;

    state_t state;
    state_t state_nxt;
    key_t key_q;
    cursor_cmd_t cmd_q;
    cursor_cmd_t ctrl_cmd;
    logic is_print;

    assign is_print = (key_q.code >= `NP_FIRST_PRINT) && (key_q.code <= `NP_LAST_PRINT);

    always_comb
    begin
        case (key_q.code)
            `NP_KEY_LEFT:  ctrl_cmd = cmd_back;
            `NP_KEY_RIGHT: ctrl_cmd = cmd_advance;
            `NP_KEY_UP:    ctrl_cmd = cmd_up;
            `NP_KEY_DOWN:  ctrl_cmd = cmd_down;
            `NP_KEY_HOME:  ctrl_cmd = cmd_home;
            `NP_KEY_END:   ctrl_cmd = cmd_end_of_line;
            `NP_KEY_ENTER: ctrl_cmd = cmd_newline;
            default:       ctrl_cmd = cmd_none;
        endcase
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (key_avail)
                begin
                    state_nxt = st_decode;
                end
            end
            st_decode:
            begin
                if (is_print)
                begin
                    state_nxt = st_glyph_wait;
                end
                else if (ctrl_cmd != cmd_none)
                begin
                    state_nxt = st_move;
                end
                else
                begin
                    state_nxt = st_idle;   // Unknown code dropped
                end
            end
            st_glyph_wait: state_nxt = st_draw;
            st_draw:
            begin
                if (draw_done)
                begin
                    state_nxt = st_move;
                end
            end
            st_move:       state_nxt = st_idle;
            default:       state_nxt = st_idle;
        endcase
    end

    assign key_pop = (state == st_idle) && key_avail;
    assign glyph_req = key_q;   // ROM output valid in glyph_wait
    assign draw_start = state == st_glyph_wait;
    assign cursor_cmd = (state == st_move) ? cmd_q : cmd_none;

    always_ff @(posedge clk)
    begin
        if (key_pop)
        begin
            key_q <= key_head;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= st_idle;
            cmd_q <= cmd_none;
        end
        else
        begin
            state <= state_nxt;
            if (state == st_decode)
            begin
                cmd_q <= is_print ? cmd_advance : ctrl_cmd;
            end
        end
    end

endmodule

// ==== rtl/pixel_emitter.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module pixel_emitter
    import notepad_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic [`NP_GLYPH_BITS-1:0] glyph,
    input  logic [5:0]                col,
    input  logic [3:0]                row,
    output logic                      pix_valid,
    output pixel_wr_t                 pix,
    input  logic                      pix_credit,
    output logic                      done
);
    localparam int CNT_W = $clog2(`NP_GLYPH_BITS);
    localparam int XW    = $clog2(`NP_GLYPH_W);
    localparam int CRD_W = $clog2(`NP_PIX_CREDITS + 1);

    logic [`NP_GLYPH_BITS-1:0] shift_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CRD_W-1:0] credits_q;
    logic busy_q;
    logic wr;
    logic last;

    assign pix_valid = busy_q && (credits_q != '0);
    assign wr = pix_valid;
    assign last = cnt_q == CNT_W'(`NP_GLYPH_BITS - 1);

    // Counter low bits pick the column inside the cell, high bits the line
    always_comb
    begin
        pix.x = 9'(col * `NP_GLYPH_W) + 9'(cnt_q[XW-1:0]);
        pix.y = 8'(row * `NP_GLYPH_H) + 8'(cnt_q[CNT_W-1:XW]);
        pix.colour = shift_q[`NP_GLYPH_BITS-1] ? `NP_FG_COLOUR : `NP_BG_COLOUR;
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            shift_q <= glyph;
        end
        else if (wr)
        begin
            shift_q <= shift_q << 1;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            credits_q <= CRD_W'(`NP_PIX_CREDITS);
            done      <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
            else if (wr)
            begin
                cnt_q <= cnt_q + 1'b1;
                if (last)
                begin
                    busy_q <= 1'b0;
                end
            end
            credits_q <= credits_q + CRD_W'(pix_credit) - CRD_W'(wr);
            done <= wr && last;   // Cycle after final write
        end
    end

endmodule

// ==== rtl/glyph_rom.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module glyph_rom
    import notepad_pkg::*;
(
    input  logic                      clk,
    input  key_t                      code,
    output logic [`NP_GLYPH_BITS-1:0] glyph
);
    // Entries for codes 0x20 up to 0x7F
    localparam int NUM_GLYPHS = 128 - `NP_FIRST_PRINT;

    logic [`NP_GLYPH_BITS-1:0] rom [NUM_GLYPHS];
    logic [6:0] idx;

    initial
    begin
        $readmemh("rtl/glyphs.hex", rom);
    end

    assign idx = code.code - `NP_FIRST_PRINT;

    always_ff @(posedge clk)
    begin
        if (code.code >= `NP_FIRST_PRINT)
        begin
            glyph <= rom[idx];   // Bit 127 is top-left
        end
    end

endmodule

// ==== rtl/cursor_pos.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module cursor_pos
    import notepad_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  cursor_cmd_t cmd,
    output logic [5:0]  col,
    output logic [3:0]  row
);
    localparam logic [5:0] MAX_COL = 6'(`NP_COLS - 1);
    localparam logic [3:0] MAX_ROW = 4'(`NP_ROWS - 1);

    logic [3:0] row_dn;   // One row lower on screen
    logic [3:0] row_up;

    assign row_dn = (row < MAX_ROW) ? row + 1'b1 : row;
    assign row_up = (row != '0) ? row - 1'b1 : row;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            col <= '0;
            row <= '0;
        end
        else
        begin
            case (cmd)
                cmd_advance:
                begin
                    if (col < MAX_COL)
                    begin
                        col <= col + 1'b1;
                    end
                    else
                    begin
                        col <= '0;   // Wrap to next line
                        row <= row_dn;
                    end
                end
                cmd_back:
                begin
                    if (col != '0)
                    begin
                        col <= col - 1'b1;
                    end
                    else
                    begin
                        col <= MAX_COL;
                        row <= row_up;
                    end
                end
                cmd_up:          row <= row_up;
                cmd_down:        row <= row_dn;
                cmd_home:        col <= '0;
                cmd_end_of_line: col <= MAX_COL;
                cmd_newline:
                begin
                    col <= '0;
                    row <= row_dn;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/key_fifo.sv ====
`timescale 1ns/10ps
`include "notepad_config.svh"

module key_fifo
    import notepad_pkg::*;
#(
    parameter int DEPTH = `NP_KEY_DEPTH
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic push,
    input  key_t push_key,
    input  logic pop,
    output logic avail,
    output key_t head,
    output logic credit
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    key_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_pop;

    assign avail = count != '0;
    assign do_pop = pop && avail;
    assign credit = do_pop;   // Slot freed for the sender
    assign head = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_key;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== rtl/notepad_pkg.sv ====
package notepad_pkg;

    typedef struct packed
    {
        logic [6:0] code;
    } key_t;

    // One frame-buffer write
    typedef struct packed
    {
        logic [8:0] x;
        logic [7:0] y;
        logic [2:0] colour;
    } pixel_wr_t;

    typedef enum logic [2:0]
    {
        cmd_none,
        cmd_advance,
        cmd_back,
        cmd_up,
        cmd_down,
        cmd_home,
        cmd_end_of_line,
        cmd_newline
    } cursor_cmd_t;

endpackage

// ==== rtl/notepad_config.svh ====
`ifndef NOTEPAD_CONFIG_SVH
`define NOTEPAD_CONFIG_SVH

// Screen geometry in characters
`define NP_COLS 40
`define NP_ROWS 15

`define NP_GLYPH_W 8
`define NP_GLYPH_H 16
`define NP_GLYPH_BITS 128

`define NP_FIRST_PRINT 7'h20
`define NP_LAST_PRINT 7'h7E

`define NP_KEY_DEPTH 4   // Also the sender's initial credits
`define NP_PIX_CREDITS 4

`define NP_FG_COLOUR 3'd2
`define NP_BG_COLOUR 3'd0

// Cursor control codes
`define NP_KEY_LEFT 7'h12
`define NP_KEY_RIGHT 7'h14
`define NP_KEY_UP 7'h11
`define NP_KEY_DOWN 7'h13
`define NP_KEY_HOME 7'h0D
`define NP_KEY_END 7'h17
`define NP_KEY_ENTER 7'h0A

`endif
